// ==== include/rv_consts.svh ====
// ====================
// RV32I core constants
// Widths, register count and reset PC
// ====================
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define RV_XLEN      32
`define RV_NUM_REGS  32
`define RV_RESET_PC  32'h0000_0000

`endif

// ==== verilog/rv_isa_pkg.sv ====
// ====================
// RV32I instruction set
// Opcodes, funct3 codes and instruction formats
// ====================
package rv_isa_pkg;

  typedef enum logic [6:0] {
    OPCODE_LOAD     = 7'b0000011,
    OPCODE_MISC_MEM = 7'b0001111,
    OPCODE_OP_IMM   = 7'b0010011,
    OPCODE_AUIPC    = 7'b0010111,
    OPCODE_STORE    = 7'b0100011,
    OPCODE_OP       = 7'b0110011,
    OPCODE_LUI      = 7'b0110111,
    OPCODE_BRANCH   = 7'b1100011,
    OPCODE_JALR     = 7'b1100111,
    OPCODE_JAL      = 7'b1101111
  } rv_opcode_t;

  // Branch compare codes
  localparam logic [2:0] rv_funct3_beq  = 3'b000;
  localparam logic [2:0] rv_funct3_bne  = 3'b001;
  localparam logic [2:0] rv_funct3_blt  = 3'b100;
  localparam logic [2:0] rv_funct3_bge  = 3'b101;
  localparam logic [2:0] rv_funct3_bltu = 3'b110;
  localparam logic [2:0] rv_funct3_bgeu = 3'b111;

  // ALU codes, shared by OP and OP-IMM
  localparam logic [2:0] rv_funct3_add_sub = 3'b000;
  localparam logic [2:0] rv_funct3_sll     = 3'b001;
  localparam logic [2:0] rv_funct3_slt     = 3'b010;
  localparam logic [2:0] rv_funct3_sltu    = 3'b011;
  localparam logic [2:0] rv_funct3_xor     = 3'b100;
  localparam logic [2:0] rv_funct3_srl_sra = 3'b101;
  localparam logic [2:0] rv_funct3_or      = 3'b110;
  localparam logic [2:0] rv_funct3_and     = 3'b111;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv_r_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_i_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } rv_s_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } rv_b_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_u_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv_j_t;

  // One fetched word, viewed in each format
  typedef union packed {
    rv_r_t r;
    rv_i_t i;
    rv_s_t s;
    rv_b_t b;
    rv_u_t u;
    rv_j_t j;
  } rv_inst_t;

endpackage

// ==== verilog/rv_ctrl_pkg.sv ====
// ====================
// Datapath select encodings
// Driven by the decoder, consumed by the datapath
// ====================
package rv_ctrl_pkg;

  typedef enum logic [1:0] {
    CTL_PC_PC4     = 2'b00,
    CTL_PC_PC_IMM  = 2'b01,
    CTL_PC_RS1_IMM = 2'b10
  } rv_pc_sel_t;

  typedef enum logic {
    CTL_ALU_A_RS1 = 1'b0,
    CTL_ALU_A_PC  = 1'b1
  } rv_alu_a_sel_t;

  typedef enum logic {
    CTL_ALU_B_RS2 = 1'b0,
    CTL_ALU_B_IMM = 1'b1
  } rv_alu_b_sel_t;

  // ALU works out the exact operation per class
  typedef enum logic [1:0] {
    CTL_ALU_ADD    = 2'b00,
    CTL_ALU_OP     = 2'b01,
    CTL_ALU_OP_IMM = 2'b10,
    CTL_ALU_BRANCH = 2'b11
  } rv_alu_class_t;

  typedef enum logic [2:0] {
    CTL_WRITEBACK_ALU  = 3'b000,
    CTL_WRITEBACK_DATA = 3'b001,
    CTL_WRITEBACK_IMM  = 3'b010,
    CTL_WRITEBACK_PC4  = 3'b011
  } rv_wb_sel_t;

endpackage

// ==== verilog/singlecycle_control.sv ====
// ====================
// Single-cycle control decoder
// Opcode to datapath selects and memory enables
// ====================
`timescale 1ns/1ps

module singlecycle_control (
  input  rv_isa_pkg::rv_opcode_t     inst_opcode,
  input  logic                       take_branch,
  output rv_ctrl_pkg::rv_pc_sel_t    next_pc_select,
  output logic                       regfile_write_enable,
  output rv_ctrl_pkg::rv_alu_a_sel_t alu_operand_a_select,
  output rv_ctrl_pkg::rv_alu_b_sel_t alu_operand_b_select,
  output rv_ctrl_pkg::rv_alu_class_t alu_op_type2,
  output logic                       data_mem_read_enable,
  output logic                       data_mem_write_enable,
  output rv_ctrl_pkg::rv_wb_sel_t    reg_writeback_select
);
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  always_comb begin
    case (inst_opcode)
      OPCODE_BRANCH: next_pc_select = take_branch ? CTL_PC_PC_IMM : CTL_PC_PC4;
      OPCODE_JALR:   next_pc_select = CTL_PC_RS1_IMM;
      OPCODE_JAL:    next_pc_select = CTL_PC_PC_IMM;
      default:       next_pc_select = CTL_PC_PC4;
    endcase
  end

  // FENCE and unknown opcodes fall to the no-op default
  always_comb begin
    case (inst_opcode)
      OPCODE_LOAD,
      OPCODE_OP_IMM,
      OPCODE_AUIPC,
      OPCODE_OP,
      OPCODE_LUI,
      OPCODE_JALR,
      OPCODE_JAL:  regfile_write_enable = 1'b1;
      default:     regfile_write_enable = 1'b0;
    endcase
  end

  always_comb begin
    case (inst_opcode)
      OPCODE_AUIPC,
      OPCODE_JAL:  alu_operand_a_select = CTL_ALU_A_PC;
      default:     alu_operand_a_select = CTL_ALU_A_RS1;
    endcase
  end

  always_comb begin
    case (inst_opcode)
      OPCODE_LOAD,
      OPCODE_OP_IMM,
      OPCODE_AUIPC,
      OPCODE_STORE,
      OPCODE_JALR,
      OPCODE_JAL:  alu_operand_b_select = CTL_ALU_B_IMM;
      default:     alu_operand_b_select = CTL_ALU_B_RS2;
    endcase
  end

  always_comb begin
    case (inst_opcode)
      OPCODE_OP_IMM: alu_op_type2 = CTL_ALU_OP_IMM;
      OPCODE_OP:     alu_op_type2 = CTL_ALU_OP;
      OPCODE_BRANCH: alu_op_type2 = CTL_ALU_BRANCH;
      default:       alu_op_type2 = CTL_ALU_ADD;
    endcase
  end

  always_comb begin
    data_mem_read_enable  = inst_opcode == OPCODE_LOAD;
    data_mem_write_enable = inst_opcode == OPCODE_STORE;
  end

  always_comb begin
    case (inst_opcode)
      OPCODE_LOAD: reg_writeback_select = CTL_WRITEBACK_DATA;
      OPCODE_LUI:  reg_writeback_select = CTL_WRITEBACK_IMM;
      OPCODE_JALR,
      OPCODE_JAL:  reg_writeback_select = CTL_WRITEBACK_PC4;
      default:     reg_writeback_select = CTL_WRITEBACK_ALU;
    endcase
  end

endmodule

// ==== verilog/rv_alu.sv ====
// ====================
// RV32I ALU
// Decodes its operation from class, funct3 and funct7
// ====================
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_alu (
  input  rv_ctrl_pkg::rv_alu_class_t alu_class,
  input  logic [2:0]                 funct3,
  input  logic                       funct7_bit5,
  input  logic [`RV_XLEN-1:0]        operand_a,
  input  logic [`RV_XLEN-1:0]        operand_b,
  output logic [`RV_XLEN-1:0]        result
);
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  localparam int shamt_w = $clog2(`RV_XLEN);

  logic [`RV_XLEN-1:0] sum;
  logic [`RV_XLEN-1:0] diff;
  logic [shamt_w-1:0]  shamt;
  logic                use_sub;
  logic [`RV_XLEN-1:0] func_result;

  assign sum   = operand_a + operand_b;
  assign diff  = operand_a - operand_b;
  assign shamt = operand_b[shamt_w-1:0];

  // Immediate forms never subtract, bit 30 there is immediate data
  assign use_sub = (alu_class == CTL_ALU_OP) && funct7_bit5;

  always_comb begin
    case (funct3)
      rv_funct3_add_sub: func_result = use_sub ? diff : sum;
      rv_funct3_sll:     func_result = operand_a << shamt;
      rv_funct3_slt: begin
        func_result = {{(`RV_XLEN-1){1'b0}}, $signed(operand_a) < $signed(operand_b)};
      end
      rv_funct3_sltu:    func_result = {{(`RV_XLEN-1){1'b0}}, operand_a < operand_b};
      rv_funct3_xor:     func_result = operand_a ^ operand_b;
      rv_funct3_srl_sra: begin
        if (funct7_bit5) begin
          func_result = $unsigned($signed(operand_a) >>> shamt);
        end else begin
          func_result = operand_a >> shamt;
        end
      end
      rv_funct3_or:      func_result = operand_a | operand_b;
      default:           func_result = operand_a & operand_b;
    endcase
  end

  always_comb begin
    case (alu_class)
      CTL_ALU_ADD:    result = sum;
      CTL_ALU_BRANCH: result = diff;
      default:        result = func_result;
    endcase
  end

endmodule

// ==== verilog/rv_regfile.sv ====
// ====================
// Integer register file
// Two read ports, one write port, x0 reads zero
// ====================
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_regfile (
  input  logic                clock,
  input  logic                write_enable,
  input  logic [4:0]          write_addr,
  input  logic [`RV_XLEN-1:0] write_data,
  input  logic [4:0]          read_addr_a,
  input  logic [4:0]          read_addr_b,
  output logic [`RV_XLEN-1:0] read_data_a,
  output logic [`RV_XLEN-1:0] read_data_b
);

  logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

  always_ff @(posedge clock) begin
    if (write_enable && write_addr != 5'd0) begin
      regs[write_addr] <= write_data;
    end
  end

  assign read_data_a = (read_addr_a == 5'd0) ? '0 : regs[read_addr_a];
  assign read_data_b = (read_addr_b == 5'd0) ? '0 : regs[read_addr_b];

endmodule

// ==== verilog/rv_datapath.sv ====
// ====================
// Single-cycle datapath
// PC, immediates, operand and writeback muxes, branch compare
// ====================
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_datapath (
  input  logic                       clock,
  input  logic                       reset,
  input  logic [`RV_XLEN-1:0]        inst_data,
  input  logic [`RV_XLEN-1:0]        data_rdata,
  input  rv_ctrl_pkg::rv_pc_sel_t    next_pc_select,
  input  logic                       regfile_write_enable,
  input  rv_ctrl_pkg::rv_alu_a_sel_t alu_operand_a_select,
  input  rv_ctrl_pkg::rv_alu_b_sel_t alu_operand_b_select,
  input  rv_ctrl_pkg::rv_alu_class_t alu_op_type2,
  input  rv_ctrl_pkg::rv_wb_sel_t    reg_writeback_select,
  output logic                       take_branch,
  output logic [`RV_XLEN-1:0]        inst_addr,
  output logic [`RV_XLEN-1:0]        data_addr,
  output logic [`RV_XLEN-1:0]        data_wdata
);
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  rv_inst_t            inst;
  logic [`RV_XLEN-1:0] pc;
  logic [`RV_XLEN-1:0] pc_plus4;
  logic [`RV_XLEN-1:0] pc_imm;
  logic [`RV_XLEN-1:0] rs1_imm;
  logic [`RV_XLEN-1:0] next_pc;
  logic [`RV_XLEN-1:0] imm;
  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;
  logic [`RV_XLEN-1:0] alu_a;
  logic [`RV_XLEN-1:0] alu_b;
  logic [`RV_XLEN-1:0] alu_result;
  logic [`RV_XLEN-1:0] wb_data;
  logic                rf_write_enable;

  assign inst = inst_data;

  // Immediate by format
  always_comb begin
    case (rv_opcode_t'(inst.r.opcode))
      OPCODE_STORE: imm = {{(`RV_XLEN-12){inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
      OPCODE_BRANCH: begin
        imm = {{(`RV_XLEN-13){inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
               inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
      end
      OPCODE_LUI,
      OPCODE_AUIPC: imm = {inst.u.imm_31_12, 12'd0};
      OPCODE_JAL: begin
        imm = {{(`RV_XLEN-21){inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
               inst.j.imm_11, inst.j.imm_10_1, 1'b0};
      end
      default:      imm = {{(`RV_XLEN-12){inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
    endcase
  end

  assign rf_write_enable = regfile_write_enable && !reset;

  rv_regfile regfile_i (
    .clock        (clock),
    .write_enable (rf_write_enable),
    .write_addr   (inst.r.rd),
    .write_data   (wb_data),
    .read_addr_a  (inst.r.rs1),
    .read_addr_b  (inst.r.rs2),
    .read_data_a  (rs1_data),
    .read_data_b  (rs2_data)
  );

  assign alu_a = (alu_operand_a_select == CTL_ALU_A_PC) ? pc : rs1_data;
  assign alu_b = (alu_operand_b_select == CTL_ALU_B_IMM) ? imm : rs2_data;

  rv_alu alu_i (
    .alu_class   (alu_op_type2),
    .funct3      (inst.r.funct3),
    .funct7_bit5 (inst.r.funct7[5]),
    .operand_a   (alu_a),
    .operand_b   (alu_b),
    .result      (alu_result)
  );

  always_comb begin
    case (inst.b.funct3)
      rv_funct3_beq:  take_branch = rs1_data == rs2_data;
      rv_funct3_bne:  take_branch = rs1_data != rs2_data;
      rv_funct3_blt:  take_branch = $signed(rs1_data) < $signed(rs2_data);
      rv_funct3_bge:  take_branch = $signed(rs1_data) >= $signed(rs2_data);
      rv_funct3_bltu: take_branch = rs1_data < rs2_data;
      rv_funct3_bgeu: take_branch = rs1_data >= rs2_data;
      default:        take_branch = 1'b0;
    endcase
  end

  always_comb begin
    case (reg_writeback_select)
      CTL_WRITEBACK_DATA: wb_data = data_rdata;
      CTL_WRITEBACK_IMM:  wb_data = imm;
      CTL_WRITEBACK_PC4:  wb_data = pc_plus4;
      default:            wb_data = alu_result;
    endcase
  end

  assign pc_plus4 = pc + `RV_XLEN'd4;
  assign pc_imm   = pc + imm;
  assign rs1_imm  = rs1_data + imm;

  always_comb begin
    case (next_pc_select)
      CTL_PC_PC_IMM:  next_pc = pc_imm;
      // JALR target drops bit 0
      CTL_PC_RS1_IMM: next_pc = {rs1_imm[`RV_XLEN-1:1], 1'b0};
      default:        next_pc = pc_plus4;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= `RV_RESET_PC;
    end else begin
      pc <= next_pc;
    end
  end

  assign inst_addr  = pc;
  assign data_addr  = alu_result;
  assign data_wdata = rs2_data;

  // Jump and branch targets from the program must keep fetch aligned
  assert property (@(posedge clock) !reset |=> pc[1:0] == 2'b00);

endmodule

// ==== verilog/rv_core.sv ====
// ====================
// RV32I single-cycle core
// Decoder and datapath on split fetch and data ports
// ====================
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_core (
  input  logic                clock,
  input  logic                reset,
  output logic [`RV_XLEN-1:0] inst_addr,
  input  logic [`RV_XLEN-1:0] inst_data,
  output logic [`RV_XLEN-1:0] data_addr,
  output logic [`RV_XLEN-1:0] data_wdata,
  input  logic [`RV_XLEN-1:0] data_rdata,
  output logic                data_read_enable,
  output logic                data_write_enable
);
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  rv_opcode_t    inst_opcode;
  logic          take_branch;
  rv_pc_sel_t    next_pc_select;
  logic          regfile_write_enable;
  rv_alu_a_sel_t alu_operand_a_select;
  rv_alu_b_sel_t alu_operand_b_select;
  rv_alu_class_t alu_op_type2;
  logic          data_mem_read_enable;
  logic          data_mem_write_enable;
  rv_wb_sel_t    reg_writeback_select;

  assign inst_opcode = rv_opcode_t'(inst_data[6:0]);

  singlecycle_control control_i (
    .inst_opcode           (inst_opcode),
    .take_branch           (take_branch),
    .next_pc_select        (next_pc_select),
    .regfile_write_enable  (regfile_write_enable),
    .alu_operand_a_select  (alu_operand_a_select),
    .alu_operand_b_select  (alu_operand_b_select),
    .alu_op_type2          (alu_op_type2),
    .data_mem_read_enable  (data_mem_read_enable),
    .data_mem_write_enable (data_mem_write_enable),
    .reg_writeback_select  (reg_writeback_select)
  );

  rv_datapath datapath_i (
    .clock                (clock),
    .reset                (reset),
    .inst_data            (inst_data),
    .data_rdata           (data_rdata),
    .next_pc_select       (next_pc_select),
    .regfile_write_enable (regfile_write_enable),
    .alu_operand_a_select (alu_operand_a_select),
    .alu_operand_b_select (alu_operand_b_select),
    .alu_op_type2         (alu_op_type2),
    .reg_writeback_select (reg_writeback_select),
    .take_branch          (take_branch),
    .inst_addr            (inst_addr),
    .data_addr            (data_addr),
    .data_wdata           (data_wdata)
  );

  // No memory traffic while held in reset
  assign data_read_enable  = data_mem_read_enable && !reset;
  assign data_write_enable = data_mem_write_enable && !reset;

  assert property (@(posedge clock) !(data_read_enable && data_write_enable));

endmodule

// ==== test/rv_core_checker.sv ====
// ====================
// RV32I core checker
// Compares stores, loads and fetches against expected values
// ====================
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_core_checker (
  input  logic                clock,
  input  logic                reset,
  input  logic [`RV_XLEN-1:0] inst_addr,
  input  logic [`RV_XLEN-1:0] inst_data,
  input  logic [`RV_XLEN-1:0] data_addr,
  input  logic [`RV_XLEN-1:0] data_wdata,
  input  logic                data_read_enable,
  input  logic                data_write_enable,
  output logic                done,
  output int                  error_count
);

  localparam int num_tests = 6;
  localparam int t_reset   = 0;
  localparam int t_alu     = 1;
  localparam int t_upper   = 2;
  localparam int t_branch  = 3;
  localparam int t_jump    = 4;
  localparam int t_x0      = 5;

  // Program operand x3, the single LW address and the closing jal x0, 0
  localparam logic [31:0] op_c      = 32'h0000_005a;
  localparam logic [31:0] load_addr = 32'd48;
  localparam logic [31:0] self_jump = 32'h0000_006f;

  string       test_names [num_tests] = '{"reset", "alu", "upper", "branch", "jump", "x0"};
  int          test_errors [num_tests] = '{default: 0};
  logic [31:0] exp_addr [$];
  logic [31:0] exp_value [$];
  int          exp_test [$];
  int          store_idx = 0;
  int          load_count = 0;
  int          errors = 0;
  logic        saw_reset = 1'b0;
  logic        pc_checked = 1'b0;
  logic        finished = 1'b0;

  assign done        = finished;
  assign error_count = errors;

  task automatic add_expected(input logic [31:0] addr, input logic [31:0] value, input int test);
    exp_addr.push_back(addr);
    exp_value.push_back(value);
    exp_test.push_back(test);
  endtask

  task automatic record_error(input int test, input string msg);
    $display("%s", msg);
    test_errors[test]++;
    errors++;
  endtask

  task automatic check_store();
    if (store_idx >= exp_addr.size()) begin
      record_error(exp_test[exp_test.size() - 1],
                   $sformatf("unexpected extra store of %h to address %h at %0t",
                             data_wdata, data_addr, $time));
    end else begin
      if (data_addr !== exp_addr[store_idx]) begin
        record_error(exp_test[store_idx],
                     $sformatf("mismatch at %0t: data_addr expected %h actual %h",
                               $time, exp_addr[store_idx], data_addr));
      end
      if (data_wdata !== exp_value[store_idx]) begin
        record_error(exp_test[store_idx],
                     $sformatf("mismatch at %0t: data_wdata expected %h actual %h",
                               $time, exp_value[store_idx], data_wdata));
      end
      store_idx++;
    end
  endtask

  task automatic check_load();
    load_count++;
    if (data_addr !== load_addr) begin
      record_error(t_upper, $sformatf("mismatch at %0t: data_addr expected %h actual %h",
                                      $time, load_addr, data_addr));
    end
  endtask

  task automatic report_results();
    int passed;
    passed = 0;
    if (!pc_checked) begin
      record_error(t_reset, "no instruction fetch was seen after reset");
    end
    if (store_idx < exp_addr.size()) begin
      record_error(exp_test[store_idx],
                   $sformatf("%0d expected stores never happened", exp_addr.size() - store_idx));
    end
    if (load_count != 1) begin
      record_error(t_upper, $sformatf("expected one load, saw %0d", load_count));
    end
    for (int t = 0; t < num_tests; t++) begin
      $display("test %s %s, %0d errors", test_names[t],
               (test_errors[t] == 0) ? "passed" : "failed", test_errors[t]);
      if (test_errors[t] == 0) begin
        passed++;
      end
    end
    $display("summary: %0d of %0d tests passed, %0d errors", passed, num_tests, errors);
    finished = 1'b1;
  endtask

  initial begin
    // The word at the reset PC stores x0
    add_expected(60, 32'd0, t_reset);
    // 100 and -7 as x1 and x2, 0x5a as x3
    add_expected(0, 32'h0000_005d, t_alu);
    add_expected(4, 32'h0000_006b, t_alu);
    add_expected(8, 32'h0000_0040, t_alu);
    add_expected(12, 32'h0000_007e, t_alu);
    add_expected(16, 32'h0000_003e, t_alu);
    add_expected(20, 32'd1, t_alu);
    add_expected(24, 32'd0, t_alu);
    // -7 shifted right by 2 keeps its sign
    add_expected(28, 32'hffff_fffe, t_alu);
    add_expected(32, 32'h0000_000f, t_alu);
    add_expected(36, 32'h0000_0640, t_alu);
    // Shift amount is 100 mod 32
    add_expected(40, 32'hffff_ffff, t_alu);
    add_expected(48, 32'h1234_5000, t_upper);
    // AUIPC at word 28
    add_expected(52, 32'd112 + 32'h0000_1000, t_upper);
    add_expected(56, 32'h1234_5000, t_upper);
    // Only the not-taken branches let their store through
    for (int k = 1; k < 12; k += 2) begin
      add_expected(64 + 4 * k, op_c, t_branch);
    end
    // Links are the address after JAL at word 56 and JALR at word 60
    add_expected(116, 32'd228, t_jump);
    add_expected(124, 32'd244, t_jump);
    add_expected(128, 32'd0, t_x0);
  end

  // Sampled mid-cycle, where the current instruction is settled
  always @(negedge clock) begin
    if (!finished) begin
      if (reset) begin
        saw_reset = 1'b1;
        if (data_write_enable) begin
          record_error(t_reset, $sformatf("store issued while reset is high at %0t", $time));
        end
      end else begin
        if (saw_reset && !pc_checked) begin
          pc_checked = 1'b1;
          if (inst_addr !== `RV_RESET_PC) begin
            record_error(t_reset, $sformatf("mismatch at %0t: inst_addr expected %h actual %h",
                                            $time, `RV_RESET_PC, inst_addr));
          end
        end
        if (inst_addr[1:0] !== 2'b00) begin
          record_error(t_jump, $sformatf("fetch from misaligned address %h at %0t",
                                         inst_addr, $time));
        end
        if (data_write_enable) begin
          check_store();
        end
        if (data_read_enable) begin
          check_load();
        end
        if (inst_data === self_jump) begin
          report_results();
        end
      end
    end
  end

endmodule

// ==== test/tb_rv_core.sv ====
// ====================
// RV32I core testbench
// Program ROM, data RAM, clock, reset and run limit
// ====================
`timescale 1ns/1ps
`include "rv_consts.svh"

module tb_rv_core;
  import rv_isa_pkg::*;

  localparam int reset_cycles = 16;
  localparam int rom_words    = 128;
  localparam int ram_words    = 64;

  logic                clock = 1'b0;
  logic                reset;
  logic [`RV_XLEN-1:0] inst_addr;
  logic [`RV_XLEN-1:0] inst_data;
  logic [`RV_XLEN-1:0] data_addr;
  logic [`RV_XLEN-1:0] data_wdata;
  logic [`RV_XLEN-1:0] data_rdata;
  logic                data_read_enable;
  logic                data_write_enable;
  logic                done;
  int                  error_count;

  logic [31:0] program_table [rom_words];
  logic [31:0] rom [rom_words];
  logic [31:0] ram [ram_words];
  int          prog_count;
  int          cycle_count = 0;
  int          timeout_cycles;

  // Branch cases {funct3, rs1, rs2}, taken then not taken for each type
  // x1 = 100 and x2 = -7
  int branch_table [12][3] = '{
    '{0, 1, 1}, '{0, 1, 2},
    '{1, 1, 2}, '{1, 1, 1},
    '{4, 2, 1}, '{4, 1, 2},
    '{5, 1, 2}, '{5, 2, 1},
    '{6, 1, 2}, '{6, 2, 1},
    '{7, 2, 1}, '{7, 1, 2}
  };

  always #20 clock = ~clock;

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
  end

  // Memory models, both read combinationally
  assign inst_data  = rom[inst_addr[8:2]];
  assign data_rdata = ram[data_addr[7:2]];

  always @(posedge clock) begin
    if (data_write_enable) begin
      ram[data_addr[7:2]] <= data_wdata;
    end
  end

  rv_core dut_i (
    .clock             (clock),
    .reset             (reset),
    .inst_addr         (inst_addr),
    .inst_data         (inst_data),
    .data_addr         (data_addr),
    .data_wdata        (data_wdata),
    .data_rdata        (data_rdata),
    .data_read_enable  (data_read_enable),
    .data_write_enable (data_write_enable)
  );

  rv_core_checker core_checker_i (
    .clock             (clock),
    .reset             (reset),
    .inst_addr         (inst_addr),
    .inst_data         (inst_data),
    .data_addr         (data_addr),
    .data_wdata        (data_wdata),
    .data_read_enable  (data_read_enable),
    .data_write_enable (data_write_enable),
    .done              (done),
    .error_count       (error_count)
  );

  function automatic logic [31:0] r_type(input logic [6:0] funct7, input logic [2:0] funct3,
                                         input int rd, input int rs1, input int rs2);
    return {funct7, rs2[4:0], rs1[4:0], funct3, rd[4:0], OPCODE_OP};
  endfunction

  function automatic logic [31:0] i_type(input logic [6:0] opcode, input logic [2:0] funct3,
                                         input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], funct3, rd[4:0], opcode};
  endfunction

  // Store word only
  function automatic logic [31:0] s_type(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OPCODE_STORE};
  endfunction

  function automatic logic [31:0] b_type(input logic [2:0] funct3, input int rs1,
                                         input int rs2, input int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], funct3, imm[4:1], imm[11], OPCODE_BRANCH};
  endfunction

  function automatic logic [31:0] u_type(input logic [6:0] opcode, input int rd, input int imm);
    return {imm[19:0], rd[4:0], opcode};
  endfunction

  function automatic logic [31:0] j_type(input int rd, input int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPCODE_JAL};
  endfunction

  task automatic append_inst(input logic [31:0] word);
    program_table[prog_count] = word;
    prog_count++;
  endtask

  task automatic append_then_store(input logic [31:0] word, input int src, input int offset);
    append_inst(word);
    append_inst(s_type(src, 0, offset));
  endtask

  task automatic build_program();
    prog_count = 0;
    // A store sits at the reset PC, so it is decoded throughout reset
    append_inst(s_type(0, 0, 60));
    // Operands x1 = 100, x2 = -7, x3 = 0x5a
    append_inst(i_type(OPCODE_OP_IMM, rv_funct3_add_sub, 1, 0, 100));
    append_inst(i_type(OPCODE_OP_IMM, rv_funct3_add_sub, 2, 0, -7));
    append_inst(i_type(OPCODE_OP_IMM, rv_funct3_add_sub, 3, 0, 32'h5a));
    append_then_store(r_type(7'h00, rv_funct3_add_sub, 4, 1, 2), 4, 0);
    append_then_store(r_type(7'h20, rv_funct3_add_sub, 4, 1, 2), 4, 4);
    append_then_store(r_type(7'h00, rv_funct3_and, 4, 1, 3), 4, 8);
    append_then_store(r_type(7'h00, rv_funct3_or, 4, 1, 3), 4, 12);
    append_then_store(r_type(7'h00, rv_funct3_xor, 4, 1, 3), 4, 16);
    append_then_store(r_type(7'h00, rv_funct3_slt, 4, 2, 1), 4, 20);
    append_then_store(r_type(7'h00, rv_funct3_sltu, 4, 2, 1), 4, 24);
    append_then_store(i_type(OPCODE_OP_IMM, rv_funct3_srl_sra, 4, 2, 32'h402), 4, 28);
    append_then_store(i_type(OPCODE_OP_IMM, rv_funct3_srl_sra, 4, 2, 28), 4, 32);
    append_then_store(i_type(OPCODE_OP_IMM, rv_funct3_sll, 4, 1, 4), 4, 36);
    append_then_store(r_type(7'h20, rv_funct3_srl_sra, 4, 2, 1), 4, 40);
    // Upper immediates, AUIPC sits at word 28
    append_then_store(u_type(OPCODE_LUI, 5, 32'h12345), 5, 48);
    append_then_store(u_type(OPCODE_AUIPC, 6, 32'h00001), 6, 52);
    append_then_store(i_type(OPCODE_LOAD, 3'b010, 7, 0, 48), 7, 56);
    // Each branch skips one store of x3 when taken
    for (int k = 0; k < 12; k++) begin
      append_inst(b_type(branch_table[k][0][2:0], branch_table[k][1], branch_table[k][2], 8));
      append_inst(s_type(3, 0, 64 + 4 * k));
    end
    // JAL at word 56, AUIPC at 59, JALR at 60 lands on 62
    append_inst(j_type(12, 8));
    append_inst(s_type(3, 0, 112));
    append_inst(s_type(12, 0, 116));
    append_inst(u_type(OPCODE_AUIPC, 13, 0));
    append_inst(i_type(OPCODE_JALR, 3'b000, 14, 13, 13));
    append_inst(s_type(3, 0, 120));
    append_inst(s_type(14, 0, 124));
    append_then_store(i_type(OPCODE_OP_IMM, rv_funct3_add_sub, 0, 0, 55), 0, 128);
    append_inst(j_type(0, 0));
  endtask

  initial begin
    reset = 1'b1;
    build_program();
    for (int i = 0; i < rom_words; i++) begin
      // Unused words hold an undefined opcode tagged with their index
      rom[i] = (i < prog_count) ? program_table[i] : {i[24:0], 7'h7f};
    end
    for (int i = 0; i < ram_words; i++) begin
      ram[i] = 32'ha5a5_0000 ^ (i * 4);
    end
    timeout_cycles = reset_cycles + 2 * prog_count + 20;
    repeat (reset_cycles) @(posedge clock);
    #2 reset = 1'b0;
    while (!done && cycle_count < timeout_cycles) begin
      @(posedge clock);
    end
    if (done && error_count == 0) begin
      $display("TEST PASS");
    end else begin
      if (!done) begin
        $display("core hang: final self-jump not reached within %0d cycles", timeout_cycles);
      end
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+include
verilog/rv_isa_pkg.sv
verilog/rv_ctrl_pkg.sv
verilog/singlecycle_control.sv
verilog/rv_alu.sv
verilog/rv_regfile.sv
verilog/rv_datapath.sv
verilog/rv_core.sv
test/rv_core_checker.sv
test/tb_rv_core.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_rv_core
./obj_dir/Vtb_rv_core | tee sim.log

if grep -q "^TEST PASS$" sim.log; then
  exit 0
fi
exit 1
